// File: hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////
  localparam int data_width    = 32;
  localparam int num_regs_log2 = 5;
  localparam int num_regs      = 2 ** num_regs_log2;
  localparam int instr_width   = 32;
  localparam int opcode_width  = 6;
  localparam int imm_width     = 16;
  localparam int shamt_width   = 5;

  // instruction field positions
  localparam int opcode_lsb = 26;
  localparam int rs_lsb     = 21;
  localparam int rt_lsb     = 16;
  localparam int rd_lsb     = 11;
  localparam int shamt_lsb  = 6;
  localparam int imm_lsb    = 0;

  typedef logic [data_width-1:0]    data_t;
  typedef logic [instr_width-1:0]   instr_t;
  typedef logic [num_regs_log2-1:0] reg_addr_t;
  typedef logic [imm_width-1:0]     imm_t;
  typedef logic [shamt_width-1:0]   shamt_t;

  //////////////////////////////
  // encodings
  //////////////////////////////

  // r-type ops write rd, i-type ops write rt
  typedef enum logic [opcode_width-1:0] {
    op_nop  = 6'd0,
    op_add  = 6'd1,
    op_sub  = 6'd2,
    op_and  = 6'd3,
    op_or   = 6'd4,
    op_slt  = 6'd5,
    op_sll  = 6'd6,
    op_addi = 6'd7,
    op_ori  = 6'd8,
    op_halt = 6'd63
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt,
    alu_sll
  } alu_op_e;

  typedef enum logic [1:0] {
    fetch_idle,
    fetch_run,
    fetch_halted
  } fetch_state_e;

endpackage

`default_nettype wire

// File: hw/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage #(
  parameter int pc_width = 6
) (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  run,
  input  wire                  imem_write,
  input  wire [pc_width-1:0]   imem_addr,
  input  wire cpu_pkg::instr_t imem_data,
  output logic                 fd_valid,
  output cpu_pkg::instr_t      fd_instr,
  output logic                 halted
);

  localparam int imem_depth = 2 ** pc_width;

  cpu_pkg::instr_t       imem [imem_depth];
  cpu_pkg::instr_t       cur_instr;
  cpu_pkg::fetch_state_e state;
  logic [pc_width-1:0]   pc;
  logic                  is_halt;
  logic                  issue;

  // program load, only used while run is low
  always_ff @(posedge clk) begin
    if (imem_write) begin
      imem[imem_addr] <= imem_data;
    end
  end

  assign cur_instr = imem[pc];
  assign is_halt   = (cur_instr[cpu_pkg::opcode_lsb +: cpu_pkg::opcode_width] == cpu_pkg::op_halt);

  // first edge with run high already issues, even from idle
  assign issue  = run && (state != cpu_pkg::fetch_halted);
  assign halted = (state == cpu_pkg::fetch_halted);

  //////////////////////////////
  // fetch state machine
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cpu_pkg::fetch_idle;
    end else begin
      case (state)
        cpu_pkg::fetch_idle, cpu_pkg::fetch_run: begin
          if (!run) begin
            state <= cpu_pkg::fetch_idle;
          end else if (is_halt) begin
            state <= cpu_pkg::fetch_halted;
          end else begin
            state <= cpu_pkg::fetch_run;
          end
        end
        // stays here until reset
        cpu_pkg::fetch_halted: state <= cpu_pkg::fetch_halted;
        default: state <= cpu_pkg::fetch_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= '0;
      fd_valid <= 1'b0;
    end else begin
      fd_valid <= issue;
      if (issue) begin
        pc <= pc + pc_width'(1);
      end
    end
  end

  // fetch/decode payload
  always_ff @(posedge clk) begin
    fd_instr <= cur_instr;
  end

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     fd_valid,
  input  wire cpu_pkg::instr_t    fd_instr,
  input  wire                     wb_valid,
  input  wire cpu_pkg::reg_addr_t wb_reg,
  input  wire cpu_pkg::data_t     wb_data,
  output logic                    de_valid,
  output cpu_pkg::alu_op_e        de_alu_op,
  output logic                    de_alu_src,
  output logic                    de_reg_write,
  output cpu_pkg::reg_addr_t      de_dest,
  output cpu_pkg::reg_addr_t      de_rs,
  output cpu_pkg::reg_addr_t      de_rt,
  output cpu_pkg::data_t          de_rs_data,
  output cpu_pkg::data_t          de_rt_data,
  output cpu_pkg::imm_t           de_imm,
  output cpu_pkg::shamt_t         de_shamt
);

  cpu_pkg::opcode_e   opcode;
  cpu_pkg::reg_addr_t rs;
  cpu_pkg::reg_addr_t rt;
  cpu_pkg::reg_addr_t rd;
  cpu_pkg::reg_addr_t dest;
  cpu_pkg::imm_t      imm;
  cpu_pkg::shamt_t    shamt;
  cpu_pkg::alu_op_e   alu_op;
  logic               alu_src;
  logic               reg_dst;
  logic               writes;
  logic               reg_write;
  cpu_pkg::data_t     regs [cpu_pkg::num_regs];
  cpu_pkg::data_t     rs_data;
  cpu_pkg::data_t     rt_data;

  // field split
  assign opcode = cpu_pkg::opcode_e'(fd_instr[cpu_pkg::opcode_lsb +: cpu_pkg::opcode_width]);
  assign rs     = fd_instr[cpu_pkg::rs_lsb +: cpu_pkg::num_regs_log2];
  assign rt     = fd_instr[cpu_pkg::rt_lsb +: cpu_pkg::num_regs_log2];
  assign rd     = fd_instr[cpu_pkg::rd_lsb +: cpu_pkg::num_regs_log2];
  assign shamt  = fd_instr[cpu_pkg::shamt_lsb +: cpu_pkg::shamt_width];
  assign imm    = fd_instr[cpu_pkg::imm_lsb +: cpu_pkg::imm_width];

  //////////////////////////////
  // control decode
  //////////////////////////////
  always_comb begin
    alu_op  = cpu_pkg::alu_add;
    alu_src = 1'b0;
    reg_dst = 1'b0;
    writes  = 1'b0;
    case (opcode)
      cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and,
      cpu_pkg::op_or, cpu_pkg::op_slt, cpu_pkg::op_sll: begin
        reg_dst = 1'b1;
        writes  = 1'b1;
      end
      cpu_pkg::op_addi, cpu_pkg::op_ori: begin
        alu_src = 1'b1;
        writes  = 1'b1;
      end
      // nop, halt and unused codes write nothing
      default: writes = 1'b0;
    endcase
    case (opcode)
      cpu_pkg::op_sub:                alu_op = cpu_pkg::alu_sub;
      cpu_pkg::op_and:                alu_op = cpu_pkg::alu_and;
      cpu_pkg::op_or, cpu_pkg::op_ori: alu_op = cpu_pkg::alu_or;
      cpu_pkg::op_slt:                alu_op = cpu_pkg::alu_slt;
      cpu_pkg::op_sll:                alu_op = cpu_pkg::alu_sll;
      default:                        alu_op = cpu_pkg::alu_add;
    endcase
  end

  assign dest      = reg_dst ? rd : rt;
  assign reg_write = writes && (dest != '0);

  //////////////////////////////
  // register file
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < cpu_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_valid) begin
      regs[wb_reg] <= wb_data;
    end
  end

  // r0 reads zero
  // same-cycle write passes straight through
  function automatic cpu_pkg::data_t read_port(cpu_pkg::reg_addr_t addr);
    cpu_pkg::data_t value;
    if (addr == '0) begin
      value = '0;
    end else if (wb_valid && (wb_reg == addr)) begin
      value = wb_data;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_comb begin
    rs_data = read_port(rs);
    rt_data = read_port(rt);
  end

  // decode/execute register
  always_ff @(posedge clk) begin
    if (reset) begin
      de_valid     <= 1'b0;
      de_reg_write <= 1'b0;
    end else begin
      de_valid     <= fd_valid;
      de_reg_write <= reg_write;
    end
  end

  always_ff @(posedge clk) begin
    de_alu_op  <= alu_op;
    de_alu_src <= alu_src;
    de_dest    <= dest;
    de_rs      <= rs;
    de_rt      <= rt;
    de_rs_data <= rs_data;
    de_rt_data <= rt_data;
    de_imm     <= imm;
    de_shamt   <= shamt;
  end

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     de_valid,
  input  wire cpu_pkg::alu_op_e   de_alu_op,
  input  wire                     de_alu_src,
  input  wire                     de_reg_write,
  input  wire cpu_pkg::reg_addr_t de_dest,
  input  wire cpu_pkg::reg_addr_t de_rs,
  input  wire cpu_pkg::reg_addr_t de_rt,
  input  wire cpu_pkg::data_t     de_rs_data,
  input  wire cpu_pkg::data_t     de_rt_data,
  input  wire cpu_pkg::imm_t      de_imm,
  input  wire cpu_pkg::shamt_t    de_shamt,
  output logic                    wb_valid,
  output cpu_pkg::reg_addr_t      wb_reg,
  output cpu_pkg::data_t          wb_data
);

  logic           fwd_a;
  logic           fwd_b;
  cpu_pkg::data_t op_a;
  cpu_pkg::data_t op_b;
  cpu_pkg::data_t src_b;
  cpu_pkg::data_t alu_result;

  //////////////////////////////
  // forwarding
  //////////////////////////////

  // previous instruction's result sits in the wb register
  // wb_valid already excludes r0 and non-writing ops
  assign fwd_a = wb_valid && (wb_reg == de_rs);
  assign fwd_b = wb_valid && (wb_reg == de_rt);

  assign op_a = fwd_a ? wb_data : de_rs_data;
  assign op_b = fwd_b ? wb_data : de_rt_data;

  // zero-extended immediate for i-type
  assign src_b = de_alu_src ? cpu_pkg::data_t'(de_imm) : op_b;

  //////////////////////////////
  // alu
  //////////////////////////////
  always_comb begin
    case (de_alu_op)
      cpu_pkg::alu_add: alu_result = op_a + src_b;
      cpu_pkg::alu_sub: alu_result = op_a - src_b;
      cpu_pkg::alu_and: alu_result = op_a & src_b;
      cpu_pkg::alu_or:  alu_result = op_a | src_b;
      // signed compare, result is 1 or 0
      cpu_pkg::alu_slt: alu_result = cpu_pkg::data_t'($signed(op_a) < $signed(src_b));
      // shifts rt, rs is ignored
      cpu_pkg::alu_sll: alu_result = src_b << de_shamt;
      default:          alu_result = '0;
    endcase
  end

  // execute/writeback register
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= de_valid && de_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    wb_reg  <= de_dest;
    wb_data <= alu_result;
  end

endmodule

`default_nettype wire

// File: hw/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top #(
  parameter int pc_width = 6
) (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  run,
  input  wire                  imem_write,
  input  wire [pc_width-1:0]   imem_addr,
  input  wire cpu_pkg::instr_t imem_data,
  output logic                 wb_valid,
  output cpu_pkg::reg_addr_t   wb_reg,
  output cpu_pkg::data_t       wb_data,
  output logic                 halted
);

  // fetch to decode
  logic               fd_valid;
  cpu_pkg::instr_t    fd_instr;

  // decode to execute
  logic               de_valid;
  cpu_pkg::alu_op_e   de_alu_op;
  logic               de_alu_src;
  logic               de_reg_write;
  cpu_pkg::reg_addr_t de_dest;
  cpu_pkg::reg_addr_t de_rs;
  cpu_pkg::reg_addr_t de_rt;
  cpu_pkg::data_t     de_rs_data;
  cpu_pkg::data_t     de_rt_data;
  cpu_pkg::imm_t      de_imm;
  cpu_pkg::shamt_t    de_shamt;

  fetch_stage #(
    .pc_width(pc_width)
  ) fetch (
    .clk(clk),
    .reset(reset),
    .run(run),
    .imem_write(imem_write),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .fd_valid(fd_valid),
    .fd_instr(fd_instr),
    .halted(halted)
  );

  // wb port doubles as the register file write port
  decode_stage decode (
    .clk(clk),
    .reset(reset),
    .fd_valid(fd_valid),
    .fd_instr(fd_instr),
    .wb_valid(wb_valid),
    .wb_reg(wb_reg),
    .wb_data(wb_data),
    .de_valid(de_valid),
    .de_alu_op(de_alu_op),
    .de_alu_src(de_alu_src),
    .de_reg_write(de_reg_write),
    .de_dest(de_dest),
    .de_rs(de_rs),
    .de_rt(de_rt),
    .de_rs_data(de_rs_data),
    .de_rt_data(de_rt_data),
    .de_imm(de_imm),
    .de_shamt(de_shamt)
  );

  execute_stage execute (
    .clk(clk),
    .reset(reset),
    .de_valid(de_valid),
    .de_alu_op(de_alu_op),
    .de_alu_src(de_alu_src),
    .de_reg_write(de_reg_write),
    .de_dest(de_dest),
    .de_rs(de_rs),
    .de_rt(de_rt),
    .de_rs_data(de_rs_data),
    .de_rt_data(de_rt_data),
    .de_imm(de_imm),
    .de_shamt(de_shamt),
    .wb_valid(wb_valid),
    .wb_reg(wb_reg),
    .wb_data(wb_data)
  );

endmodule

`default_nettype wire

// File: tb/cpu_tests.svh
`ifndef cpu_tests_svh
`define cpu_tests_svh

//////////////////////////////
// program building
//////////////////////////////

function automatic cpu_pkg::instr_t r_instr(cpu_pkg::opcode_e op, int rd, int rs, int rt,
                                            int sh);
  return {op, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'b0};
endfunction

function automatic cpu_pkg::instr_t i_instr(cpu_pkg::opcode_e op, int rt, int rs,
                                            cpu_pkg::imm_t imm);
  return {op, 5'(rs), 5'(rt), imm};
endfunction

function automatic cpu_pkg::instr_t halt_instr();
  return {cpu_pkg::op_halt, 26'b0};
endfunction

// never zero, so a subtract from r0 goes negative
function automatic cpu_pkg::imm_t rand_imm();
  return cpu_pkg::imm_t'($random(seed)) | 16'h1;
endfunction

// replays the program on a register array, queueing each write in order
task automatic build_expected();
  cpu_pkg::data_t     model_regs [32];
  cpu_pkg::instr_t    ins;
  logic [5:0]         op;
  cpu_pkg::reg_addr_t rs, rt, rd, dest;
  cpu_pkg::data_t     a, b, val;
  logic               writes;
  logic               stop;
  for (int r = 0; r < 32; r++) begin
    model_regs[r] = '0;
  end
  exp_reg.delete();
  exp_data.delete();
  stop = 1'b0;
  for (int i = 0; i < prog.size() && !stop; i++) begin
    ins    = prog[i];
    op     = ins[31:26];
    rs     = ins[25:21];
    rt     = ins[20:16];
    rd     = ins[15:11];
    a      = model_regs[rs];
    b      = model_regs[rt];
    val    = '0;
    dest   = rd;
    writes = 1'b1;
    case (op)
      cpu_pkg::op_add: val = a + b;
      cpu_pkg::op_sub: val = a - b;
      cpu_pkg::op_and: val = a & b;
      cpu_pkg::op_or:  val = a | b;
      cpu_pkg::op_slt: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      cpu_pkg::op_sll: val = b << ins[10:6];
      cpu_pkg::op_addi: begin
        val  = a + {16'h0, ins[15:0]};
        dest = rt;
      end
      cpu_pkg::op_ori: begin
        val  = a | {16'h0, ins[15:0]};
        dest = rt;
      end
      cpu_pkg::op_halt: begin
        writes = 1'b0;
        stop   = 1'b1;
      end
      default: writes = 1'b0;
    endcase
    // r0 never changes and never retires
    if (writes && dest != 5'd0) begin
      model_regs[dest] = val;
      exp_reg.push_back(dest);
      exp_data.push_back(val);
    end
  end
endtask

task automatic load_program();
  for (int i = 0; i < prog.size(); i++) begin
    @(negedge clk);
    imem_write = 1'b1;
    imem_addr  = pc_width'(i);
    imem_data  = prog[i];
  end
  @(negedge clk);
  imem_write = 1'b0;
endtask

// pause_after > 0 drops run for a while after that many cycles
task automatic run_program(input bit check_latency, input int pause_after);
  int n;
  reset_dut();
  load_program();
  build_expected();
  run = 1'b1;
  if (check_latency) begin
    for (int i = 1; i <= 3; i++) begin
      @(negedge clk);
      if (wb_valid !== (i == 3)) begin
        other_errors++;
        $display("first retirement not 3 edges after run rose (edge %0d)", i);
      end
    end
  end
  if (pause_after > 0) begin
    repeat (pause_after) @(negedge clk);
    run = 1'b0;
    // in-flight instructions drain within two edges
    repeat (3) @(negedge clk);
    repeat (5) begin
      @(negedge clk);
      if (wb_valid) begin
        other_errors++;
        $display("retirement seen while run was low at %0t", $time);
      end
    end
    run = 1'b1;
  end
  n = 0;
  while (!halted && n < 100) begin
    @(negedge clk);
    n++;
  end
  if (!halted) begin
    other_errors++;
    $display("halted never went high after the halt instruction");
  end
  // two edges of drain, then ten quiet cycles under the monitor
  repeat (12) @(negedge clk);
  @(posedge clk);
  if (exp_reg.size() != 0) begin
    other_errors++;
    $display("%0d expected retirements never appeared", exp_reg.size());
  end
  @(negedge clk);
  run = 1'b0;
endtask

//////////////////////////////
// directed tests
//////////////////////////////

task automatic reset_and_latency();
  prog.delete();
  prog.push_back(i_instr(cpu_pkg::op_addi, 1, 0, 16'h1234));
  prog.push_back(i_instr(cpu_pkg::op_addi, 2, 1, 16'h0001));
  prog.push_back(halt_instr());
  run_program(1'b1, 0);
endtask

task automatic alu_ops();
  prog.delete();
  prog.push_back(i_instr(cpu_pkg::op_addi, 1, 0, rand_imm()));
  prog.push_back(i_instr(cpu_pkg::op_ori, 2, 0, rand_imm()));
  prog.push_back(i_instr(cpu_pkg::op_addi, 3, 0, rand_imm()));
  prog.push_back(i_instr(cpu_pkg::op_ori, 4, 0, rand_imm()));
  prog.push_back(r_instr(cpu_pkg::op_add, 6, 1, 2, 0));
  prog.push_back(r_instr(cpu_pkg::op_sub, 7, 0, 2, 0));
  prog.push_back(r_instr(cpu_pkg::op_and, 8, 3, 4, 0));
  prog.push_back(r_instr(cpu_pkg::op_or, 9, 1, 4, 0));
  prog.push_back(r_instr(cpu_pkg::op_sub, 13, 0, 3, 0));
  // negative against positive, then two negatives
  prog.push_back(r_instr(cpu_pkg::op_slt, 10, 7, 1, 0));
  prog.push_back(r_instr(cpu_pkg::op_slt, 11, 1, 7, 0));
  prog.push_back(r_instr(cpu_pkg::op_slt, 12, 7, 13, 0));
  prog.push_back(r_instr(cpu_pkg::op_slt, 14, 13, 7, 0));
  prog.push_back(r_instr(cpu_pkg::op_sll, 15, 0, 3, 5));
  prog.push_back(r_instr(cpu_pkg::op_sll, 16, 0, 7, 31));
  prog.push_back(halt_instr());
  run_program(1'b0, 0);
endtask

task automatic forward_chain();
  prog.delete();
  prog.push_back(i_instr(cpu_pkg::op_addi, 1, 0, rand_imm()));
  prog.push_back(i_instr(cpu_pkg::op_addi, 2, 1, rand_imm()));
  prog.push_back(r_instr(cpu_pkg::op_add, 3, 2, 2, 0));
  prog.push_back(r_instr(cpu_pkg::op_sub, 4, 1, 3, 0));
  prog.push_back(r_instr(cpu_pkg::op_and, 5, 4, 3, 0));
  prog.push_back(r_instr(cpu_pkg::op_or, 6, 2, 5, 0));
  prog.push_back(r_instr(cpu_pkg::op_slt, 7, 4, 6, 0));
  prog.push_back(r_instr(cpu_pkg::op_sll, 8, 0, 7, 4));
  prog.push_back(i_instr(cpu_pkg::op_ori, 9, 8, rand_imm()));
  prog.push_back(r_instr(cpu_pkg::op_add, 10, 9, 9, 0));
  prog.push_back(halt_instr());
  run_program(1'b0, 0);
endtask

task automatic distance_deps();
  prog.delete();
  prog.push_back(i_instr(cpu_pkg::op_addi, 1, 0, rand_imm()));
  prog.push_back(i_instr(cpu_pkg::op_ori, 20, 0, rand_imm()));
  // r1 two apart on rt
  prog.push_back(r_instr(cpu_pkg::op_add, 2, 0, 1, 0));
  prog.push_back(i_instr(cpu_pkg::op_ori, 21, 0, rand_imm()));
  prog.push_back(i_instr(cpu_pkg::op_ori, 22, 0, rand_imm()));
  // r2 three apart on rs
  prog.push_back(r_instr(cpu_pkg::op_sub, 3, 2, 20, 0));
  prog.push_back(i_instr(cpu_pkg::op_ori, 23, 0, rand_imm()));
  prog.push_back(r_instr(cpu_pkg::op_or, 4, 3, 1, 0));
  prog.push_back(i_instr(cpu_pkg::op_ori, 24, 0, rand_imm()));
  prog.push_back(i_instr(cpu_pkg::op_ori, 25, 0, rand_imm()));
  prog.push_back(r_instr(cpu_pkg::op_and, 5, 1, 4, 0));
  prog.push_back(halt_instr());
  run_program(1'b0, 0);
endtask

task automatic zero_register();
  prog.delete();
  prog.push_back(i_instr(cpu_pkg::op_addi, 0, 0, rand_imm()));
  prog.push_back(i_instr(cpu_pkg::op_addi, 1, 0, rand_imm()));
  prog.push_back(r_instr(cpu_pkg::op_add, 0, 1, 1, 0));
  prog.push_back(r_instr(cpu_pkg::op_add, 2, 0, 1, 0));
  prog.push_back(i_instr(cpu_pkg::op_ori, 0, 1, rand_imm()));
  prog.push_back(r_instr(cpu_pkg::op_or, 3, 0, 0, 0));
  prog.push_back(halt_instr());
  run_program(1'b0, 0);
endtask

task automatic run_pause();
  prog.delete();
  prog.push_back(i_instr(cpu_pkg::op_addi, 1, 0, rand_imm()));
  prog.push_back(i_instr(cpu_pkg::op_addi, 2, 1, rand_imm()));
  prog.push_back(r_instr(cpu_pkg::op_add, 3, 1, 2, 0));
  prog.push_back(r_instr(cpu_pkg::op_sub, 4, 3, 1, 0));
  prog.push_back(r_instr(cpu_pkg::op_sll, 5, 0, 4, 3));
  prog.push_back(r_instr(cpu_pkg::op_or, 6, 5, 2, 0));
  prog.push_back(r_instr(cpu_pkg::op_slt, 7, 4, 6, 0));
  prog.push_back(i_instr(cpu_pkg::op_ori, 8, 6, rand_imm()));
  prog.push_back(r_instr(cpu_pkg::op_and, 9, 8, 3, 0));
  prog.push_back(halt_instr());
  run_program(1'b0, 4);
endtask

`endif

// File: tb/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

  localparam int pc_width   = 6;
  localparam int max_cycles = 600;

  logic                clk;
  logic                reset;
  logic                run;
  logic                imem_write;
  logic [pc_width-1:0] imem_addr;
  cpu_pkg::instr_t     imem_data;
  logic                wb_valid;
  cpu_pkg::reg_addr_t  wb_reg;
  cpu_pkg::data_t      wb_data;
  logic                halted;

  // program under test and the retirements it should produce
  cpu_pkg::instr_t    prog [$];
  cpu_pkg::reg_addr_t exp_reg [$];
  cpu_pkg::data_t     exp_data [$];
  cpu_pkg::reg_addr_t next_reg;
  cpu_pkg::data_t     next_data;

  integer seed         = 32'h7cc5e623;
  int     cycles       = 0;
  int     value_errors = 0;
  int     other_errors = 0;

  cpu_top #(
    .pc_width(pc_width)
  ) uut (
    .clk(clk),
    .reset(reset),
    .run(run),
    .imem_write(imem_write),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .wb_valid(wb_valid),
    .wb_reg(wb_reg),
    .wb_data(wb_data),
    .halted(halted)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // writeback monitor
  //////////////////////////////
  always @(negedge clk) begin
    if (!reset && wb_valid) begin
      if (exp_reg.size() == 0) begin
        other_errors++;
        $display("unexpected retirement to r%0d at %0t", wb_reg, $time);
      end else begin
        next_reg  = exp_reg.pop_front();
        next_data = exp_data.pop_front();
        if (wb_reg !== next_reg || wb_data !== next_data) begin
          value_errors++;
          $display("** Error at %0t: got r%0d = %h, expected r%0d = %h",
                   $time, wb_reg, wb_data, next_reg, next_data);
        end
      end
    end
  end

  // whole run is bounded, a stuck pipe ends here
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout after %0d cycles, tests did not finish", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic reset_dut();
    @(negedge clk);
    run        = 1'b0;
    imem_write = 1'b0;
    reset      = 1'b1;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    if (wb_valid || halted) begin
      other_errors++;
      $display("wb_valid or halted not low after reset at %0t", $time);
    end
  endtask

  `include "cpu_tests.svh"

  initial begin
    reset      = 1'b1;
    run        = 1'b0;
    imem_write = 1'b0;
    imem_addr  = '0;
    imem_data  = '0;
    reset_and_latency();
    alu_ops();
    forward_chain();
    distance_deps();
    zero_register();
    run_pause();
    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+tb
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/cpu_top.sv
tb/cpu_tb.sv

// File: run.sh
#!/bin/sh
# builds the cpu testbench with verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module cpu_tb \
  --Mdir obj_dir -o cpu_sim \
  -f files.f

./obj_dir/cpu_sim > sim.log
cat sim.log

if grep -q "All tests passed!" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
